// ==== rtl/adc_capture_top.sv ====
`timescale 1ns/10ps

module adc_capture_top
  import adc_if_pkg::*;
(
  input  logic    delay_clk,
  input  logic    rst_n,
  input  logic    enable,
  input  logic    busy,
  input  logic    echo_sclk,
  input  lanes_t  sdi,
  output logic    cnv,
  output logic    spi_cs,
  output logic    spi_sclk,
  output logic    sample_valid,
  output sample_t sample_data,
  input  logic    credit_return
);

  // Frame start from the sequencer to the deserializer
  logic start_capture;
  // Finished sample, also tells the sequencer the frame is over
  logic cap_valid;
  sample_t cap_data;
  // FIFO can still take one more sample
  logic fifo_room;

  // ******************************************************************
  // Conversion control, capture and output stream
  // ******************************************************************
  conv_sequencer u_conv_sequencer (
    .delay_clk     (delay_clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .fifo_room     (fifo_room),
    .busy          (busy),
    .cap_valid     (cap_valid),
    .cnv           (cnv),
    .spi_cs        (spi_cs),
    .spi_sclk      (spi_sclk),
    .start_capture (start_capture)
  );

  echo_capture u_echo_capture (
    .delay_clk     (delay_clk),
    .rst_n         (rst_n),
    .start_capture (start_capture),
    .echo_sclk     (echo_sclk),
    .sdi           (sdi),
    .cap_valid     (cap_valid),
    .cap_data      (cap_data)
  );

  sample_credit_out u_sample_credit_out (
    .delay_clk     (delay_clk),
    .rst_n         (rst_n),
    .cap_valid     (cap_valid),
    .cap_data      (cap_data),
    .credit_return (credit_return),
    .fifo_room     (fifo_room),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data)
  );

endmodule

// ==== rtl/adc_if_defines.svh ====
`ifndef ADC_IF_DEFINES_SVH
`define ADC_IF_DEFINES_SVH

// ******************************************************************
// ADC front end geometry
// ******************************************************************

// Number of SDI lanes the ADC drives in parallel
`define ADC_NUM_LANES 4

// Bits in one assembled conversion result
`define ADC_SAMPLE_WIDTH 16

// Each lane carries an equal slice of the sample per read frame
`define ADC_BITS_PER_LANE (`ADC_SAMPLE_WIDTH / `ADC_NUM_LANES)

// ******************************************************************
// Serial clock and output stream
// ******************************************************************

// delay_clk cycles spent in each half period of spi_sclk
`define SCLK_HALF_CYCLES 2

// Depth of the sample FIFO ahead of the stream
`define OUT_FIFO_DEPTH 4

// Credits the consumer grants right after reset
`define OUT_CREDITS 2

`endif

// ==== rtl/adc_if_pkg.sv ====
`include "adc_if_defines.svh"

package adc_if_pkg;

  // ******************************************************************
  // Vector types with a meaning of their own
  // ******************************************************************

  // One conversion result, lane 0 in the top slice
  typedef logic [`ADC_SAMPLE_WIDTH-1:0] sample_t;

  // One bit per SDI lane, bit i is lane i
  typedef logic [`ADC_NUM_LANES-1:0] lanes_t;

  // Counts edges or periods within one frame, it must reach ADC_BITS_PER_LANE itself
  typedef logic [$clog2(`ADC_BITS_PER_LANE + 1)-1:0] lane_bit_cnt_t;

  // FIFO fill level, from empty up to completely full
  typedef logic [$clog2(`OUT_FIFO_DEPTH + 1)-1:0] fifo_cnt_t;

  // Credits held towards the consumer
  typedef logic [$clog2(`OUT_CREDITS + 1)-1:0] credit_cnt_t;

  // Conversion sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_convert,
    st_wait_busy,
    st_clocking,
    st_wait_capture
  } seq_state_t;

endpackage

// ==== rtl/conv_sequencer.sv ====
`timescale 1ns/10ps
`include "adc_if_defines.svh"

module conv_sequencer
  import adc_if_pkg::*;
(
  input  logic delay_clk,
  input  logic rst_n,
  input  logic enable,
  input  logic fifo_room,
  input  logic busy,
  input  logic cap_valid,
  output logic cnv,
  output logic spi_cs,
  output logic spi_sclk,
  output logic start_capture
);

  // Half period counter width, kept at least one bit wide
  localparam int HALF_W = $clog2(`SCLK_HALF_CYCLES + 1);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SCLK_HALF_CYCLES - 1);
  localparam lane_bit_cnt_t FRAME_PERIODS = lane_bit_cnt_t'(`ADC_BITS_PER_LANE);

  seq_state_t state;
  logic [HALF_W-1:0] half_cnt;
  lane_bit_cnt_t per_cnt;
  logic cap_seen;

  // Half period boundary of the serial clock
  logic half_done;
  assign half_done = (half_cnt == HALF_LAST);

  // ******************************************************************
  // Conversion and frame state machine
  // ******************************************************************
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= st_idle;
      cnv           <= 1'b0;
      spi_cs        <= 1'b1;
      spi_sclk      <= 1'b0;
      start_capture <= 1'b0;
      half_cnt      <= '0;
      per_cnt       <= '0;
    end else begin
      // Both strobes are single cycle pulses
      cnv           <= 1'b0;
      start_capture <= 1'b0;
      case (state)
        st_idle: begin
          // A new conversion only starts when the FIFO can take its result
          if (enable && fifo_room) begin
            cnv   <= 1'b1;
            state <= st_convert;
          end
        end
        st_convert: begin
          // Wait for the ADC to acknowledge cnv with busy
          if (busy) begin
            state <= st_wait_busy;
          end
        end
        st_wait_busy: begin
          // Falling busy opens the read frame on the next cycle
          if (!busy) begin
            spi_cs        <= 1'b0;
            spi_sclk      <= 1'b1;
            start_capture <= 1'b1;
            half_cnt      <= '0;
            per_cnt       <= '0;
            state         <= st_clocking;
          end
        end
        st_clocking: begin
          if (half_done) begin
            half_cnt <= '0;
            if (spi_sclk) begin
              // Falling edge closes one full period
              spi_sclk <= 1'b0;
              per_cnt  <= per_cnt + 1'b1;
            end else if (per_cnt == FRAME_PERIODS) begin
              // Last low phase done, release chip select
              spi_cs <= 1'b1;
              state  <= st_wait_capture;
            end else begin
              spi_sclk <= 1'b1;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        st_wait_capture: begin
          // With a short echo delay the capture may have finished already
          if (cap_valid || cap_seen) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Remembers a capture that ends while the frame is still being clocked
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_seen <= 1'b0;
    end else if (state == st_wait_busy && !busy) begin
      cap_seen <= 1'b0;
    end else if (cap_valid) begin
      cap_seen <= 1'b1;
    end
  end

endmodule

// ==== rtl/echo_capture.sv ====
`timescale 1ns/10ps
`include "adc_if_defines.svh"

module echo_capture
  import adc_if_pkg::*;
(
  input  logic    delay_clk,
  input  logic    rst_n,
  input  logic    start_capture,
  input  logic    echo_sclk,
  input  lanes_t  sdi,
  output logic    cap_valid,
  output sample_t cap_data
);

  localparam int BITS = `ADC_BITS_PER_LANE;
  localparam lane_bit_cnt_t LAST_EDGE = lane_bit_cnt_t'(BITS - 1);
  localparam lane_bit_cnt_t DONE_CNT = lane_bit_cnt_t'(BITS);

  logic echo_q;
  logic echo_q_d;
  lanes_t sdi_q;
  logic echo_rise;
  lane_bit_cnt_t edge_cnt;

  // Per lane shift registers and their value after the current edge
  logic [BITS-1:0] lane_sr [`ADC_NUM_LANES];
  logic [BITS-1:0] lane_next [`ADC_NUM_LANES];
  sample_t sample_next;

  // ******************************************************************
  // Input register stage
  // ******************************************************************

  // Echo and data share one stage so they keep the delay the ADC gave them
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      echo_q   <= 1'b0;
      echo_q_d <= 1'b0;
    end else begin
      echo_q   <= echo_sclk;
      echo_q_d <= echo_q;
    end
  end

  always_ff @(posedge delay_clk) begin
    sdi_q <= sdi;
  end

  assign echo_rise = echo_q & ~echo_q_d;

  // ******************************************************************
  // Lane deserializers
  // ******************************************************************

  // Each lane arrives MSB first, lane 0 lands in the top slice
  always_comb begin
    for (int i = 0; i < `ADC_NUM_LANES; i++) begin
      lane_next[i] = {lane_sr[i][BITS-2:0], sdi_q[i]};
      sample_next[`ADC_SAMPLE_WIDTH-1-i*BITS -: BITS] = lane_next[i];
    end
  end

  always_ff @(posedge delay_clk) begin
    if (echo_rise) begin
      for (int i = 0; i < `ADC_NUM_LANES; i++) begin
        lane_sr[i] <= lane_next[i];
      end
    end
  end

  // Edge counter parks at DONE_CNT so stray echo edges are ignored
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt  <= DONE_CNT;
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= 1'b0;
      if (start_capture) begin
        edge_cnt <= '0;
      end else if (echo_rise && edge_cnt != DONE_CNT) begin
        edge_cnt <= edge_cnt + 1'b1;
        cap_valid <= (edge_cnt == LAST_EDGE);
      end
    end
  end

  // The whole sample is taken on the last edge of the frame
  always_ff @(posedge delay_clk) begin
    if (echo_rise && edge_cnt == LAST_EDGE) begin
      cap_data <= sample_next;
    end
  end

endmodule

// ==== rtl/sample_credit_out.sv ====
`timescale 1ns/10ps
`include "adc_if_defines.svh"

module sample_credit_out
  import adc_if_pkg::*;
(
  input  logic    delay_clk,
  input  logic    rst_n,
  input  logic    cap_valid,
  input  sample_t cap_data,
  input  logic    credit_return,
  output logic    fifo_room,
  output logic    sample_valid,
  output sample_t sample_data
);

  localparam int DEPTH = `OUT_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  sample_t fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_cnt_t fifo_cnt;
  credit_cnt_t credit_cnt;
  logic send;

  // A sample leaves when one is stored and the consumer has a slot for it
  assign send = (fifo_cnt != '0) && (credit_cnt != '0);

  // The sequencer holds off new conversions while this is low
  assign fifo_room = (fifo_cnt < fifo_cnt_t'(DEPTH));

  // ******************************************************************
  // Circular buffer
  // ******************************************************************
  always_ff @(posedge delay_clk) begin
    if (cap_valid) begin
      fifo_mem[wr_ptr] <= cap_data;
    end
  end

  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (cap_valid) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy moves by at most one, a push and a pop together cancel
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_cnt <= '0;
    end else begin
      case ({cap_valid, send})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // ******************************************************************
  // Credit accounting and the registered stream
  // ******************************************************************
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= credit_cnt_t'(`OUT_CREDITS);
    end else begin
      case ({send, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= send;
    end
  end

  // Head entry goes out together with the valid strobe
  always_ff @(posedge delay_clk) begin
    if (send) begin
      sample_data <= fifo_mem[rd_ptr];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ADC capture testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module adc_capture_tb -o adc_capture_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/adc_capture_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Simulation did not report a clean run"
exit 1

// ==== sim/adc_capture_tb.sv ====
`timescale 1ns/10ps
`include "adc_if_defines.svh"

module adc_capture_tb
  import adc_if_pkg::*;
();

  localparam int CLK_PERIOD_NS = 20;
  // Samples over all tests are 40 prompt plus 3 x 20 swept plus 40 withheld plus 1 enable drop
  localparam int TOTAL_SAMPLES = 141;
  // Busy, frame and 31 cycle echo plus room for a withheld credit phase
  localparam int WORST_FRAME_CYCLES = 250;
  localparam int MARGIN_CYCLES = 3000;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * WORST_FRAME_CYCLES + MARGIN_CYCLES;

  logic delay_clk;
  logic rst_n;
  logic enable = 1'b0;
  logic credit_return = 1'b0;
  logic credit_hold = 1'b0;
  logic [5:0] echo_delay = '0;
  logic busy;
  logic echo_sclk;
  lanes_t sdi;
  logic cnv;
  logic spi_cs;
  logic spi_sclk;
  logic sample_valid;
  sample_t sample_data;
  sample_t model_sample;
  logic model_strobe;

  // Reference results in conversion order
  sample_t ref_q [$];
  int errors = 0;
  int cnv_total = 0;
  int delivered = 0;
  int outstanding = 0;
  int max_backlog = 0;
  int test_num = 0;
  int tests_failed = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clk0 (
    .delay_clk (delay_clk),
    .rst_n     (rst_n)
  );

  adc_echo_model adc0 (
    .delay_clk    (delay_clk),
    .rst_n        (rst_n),
    .echo_delay   (echo_delay),
    .cnv          (cnv),
    .spi_cs       (spi_cs),
    .spi_sclk     (spi_sclk),
    .busy         (busy),
    .echo_sclk    (echo_sclk),
    .sdi          (sdi),
    .model_sample (model_sample),
    .model_strobe (model_strobe)
  );

  adc_capture_top dut0 (
    .delay_clk     (delay_clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .busy          (busy),
    .echo_sclk     (echo_sclk),
    .sdi           (sdi),
    .cnv           (cnv),
    .spi_cs        (spi_cs),
    .spi_sclk      (spi_sclk),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .credit_return (credit_return)
  );

  // ******************************************************************
  // Stream checker and credit consumer
  // ******************************************************************
  always @(posedge delay_clk) begin
    sample_t expected;
    int next_out;
    int backlog;
    if (rst_n) begin
      if (model_strobe) begin
        ref_q.push_back(model_sample);
      end
      if (sample_valid) begin
        assert (ref_q.size() > 0) else begin
          $display("ERROR %0t: sample 0x%04h with no conversion behind it", $time, sample_data);
          errors++;
        end
        if (ref_q.size() > 0) begin
          expected = ref_q.pop_front();
          assert (sample_data == expected) else begin
            $display("ERROR %0t: sample 0x%04h, expected 0x%04h", $time, sample_data, expected);
            errors++;
          end
        end
      end
      // Samples held by the consumer and not yet paid back with a credit
      next_out = outstanding + int'(sample_valid) - int'(credit_return);
      assert (next_out >= 0 && next_out <= `OUT_CREDITS) else begin
        $display("ERROR %0t: %0d samples outstanding, credit limit is %0d",
                 $time, next_out, `OUT_CREDITS);
        errors++;
      end
      backlog = (cnv_total + int'(cnv)) - (delivered + int'(sample_valid));
      assert (backlog <= `OUT_FIFO_DEPTH + `OUT_CREDITS) else begin
        $display("ERROR %0t: %0d conversions ahead of delivered samples", $time, backlog);
        errors++;
      end
      if (backlog > max_backlog) begin
        max_backlog <= backlog;
      end
      // One credit goes back per cycle while the consumer is not holding them
      if (next_out > 0 && !credit_hold) begin
        credit_return <= 1'b1;
      end else begin
        credit_return <= 1'b0;
      end
      cnv_total   <= cnv_total + int'(cnv);
      delivered   <= delivered + int'(sample_valid);
      outstanding <= next_out;
    end
  end

  // ******************************************************************
  // Test sequences
  // ******************************************************************

  // Prints one line for a finished test
  task automatic report_test(input string name, input int err_before, input int samples);
    test_num++;
    if (errors == err_before) begin
      $display("test %0d %s: %0d samples, pass", test_num, name, samples);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d samples, fail", test_num, name, samples);
    end
  endtask

  task automatic check_quiet_pins(input int cycles);
    repeat (cycles) begin
      @(posedge delay_clk);
      assert (spi_cs && !cnv && !spi_sclk && !sample_valid) else begin
        $display("ERROR %0t: pins not idle, spi_cs=%b cnv=%b spi_sclk=%b sample_valid=%b",
                 $time, spi_cs, cnv, spi_sclk, sample_valid);
        errors++;
      end
    end
  endtask

  // Waits until every conversion has been delivered and paid back, or a frame time has passed
  task automatic drain_stream();
    int waited;
    credit_hold <= 1'b0;
    waited = 0;
    repeat (4) @(posedge delay_clk);
    while ((delivered != cnv_total || outstanding != 0) && waited < WORST_FRAME_CYCLES) begin
      @(posedge delay_clk);
      waited++;
    end
    // Lets the echo pipeline fall quiet before the delay is changed
    repeat (40) @(posedge delay_clk);
    assert (ref_q.size() == 0) else begin
      $display("ERROR %0t: %0d model samples were never delivered", $time, ref_q.size());
      errors++;
    end
  endtask

  task automatic stream_samples(input int delay, input int count);
    int target;
    @(posedge delay_clk);
    echo_delay <= 6'(delay);
    target = delivered + count;
    enable <= 1'b1;
    while (delivered < target) begin
      @(posedge delay_clk);
    end
    enable <= 1'b0;
    drain_stream();
  endtask

  // Credits are held back for random stretches so the FIFO fills
  task automatic withhold_credits(input int delay, input int count);
    int target;
    int hold_len;
    int free_len;
    @(posedge delay_clk);
    echo_delay <= 6'(delay);
    target = delivered + count;
    enable <= 1'b1;
    while (delivered < target) begin
      hold_len = int'($urandom_range(400, 250));
      free_len = int'($urandom_range(50, 20));
      credit_hold <= 1'b1;
      repeat (hold_len) @(posedge delay_clk);
      credit_hold <= 1'b0;
      repeat (free_len) @(posedge delay_clk);
    end
    enable <= 1'b0;
    drain_stream();
    assert (max_backlog >= `OUT_FIFO_DEPTH) else begin
      $display("ERROR %0t: backlog only reached %0d, the FIFO never filled", $time, max_backlog);
      errors++;
    end
  endtask

  // Drops enable once chip select is low and watches the frame finish
  task automatic drop_enable_mid_frame(input int delay);
    int cnv_start;
    int del_start;
    @(posedge delay_clk);
    echo_delay <= 6'(delay);
    cnv_start = cnv_total;
    del_start = delivered;
    enable <= 1'b1;
    while (spi_cs) begin
      @(posedge delay_clk);
    end
    enable <= 1'b0;
    drain_stream();
    assert (cnv_total - cnv_start == 1) else begin
      $display("ERROR %0t: %0d conversions after enable fell, expected 1",
               $time, cnv_total - cnv_start);
      errors++;
    end
    assert (delivered - del_start == 1) else begin
      $display("ERROR %0t: %0d samples from the cut frame, expected 1",
               $time, delivered - del_start);
      errors++;
    end
    repeat (200) begin
      @(posedge delay_clk);
      assert (!cnv) else begin
        $display("ERROR %0t: cnv pulse while enable is low", $time);
        errors++;
      end
    end
  endtask

  initial begin
    int err_before;
    void'($urandom(32'h5687446c));
    @(posedge rst_n);

    err_before = errors;
    check_quiet_pins(20);
    report_test("idle pins after reset", err_before, 0);

    err_before = errors;
    stream_samples(18, 40);
    report_test("echo delay 18, prompt credits", err_before, 40);

    err_before = errors;
    stream_samples(0, 20);
    report_test("echo delay 0", err_before, 20);

    err_before = errors;
    stream_samples(5, 20);
    report_test("echo delay 5", err_before, 20);

    err_before = errors;
    stream_samples(31, 20);
    report_test("echo delay 31", err_before, 20);

    err_before = errors;
    withhold_credits(12, 40);
    report_test("credits withheld at random", err_before, 40);

    err_before = errors;
    drop_enable_mid_frame(9);
    report_test("enable falls mid-frame", err_before, 1);

    $display("tests %0d, failed %0d, samples checked %0d, errors %0d",
             test_num, tests_failed, delivered, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // ******************************************************************
  // Watchdog
  // ******************************************************************
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("The run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== sim/adc_echo_model.sv ====
`timescale 1ns/10ps
`include "adc_if_defines.svh"

module adc_echo_model
  import adc_if_pkg::*;
#(
  parameter int MAX_DELAY = 32
) (
  input  logic       delay_clk,
  input  logic       rst_n,
  input  logic [5:0] echo_delay,
  input  logic       cnv,
  input  logic       spi_cs,
  input  logic       spi_sclk,
  output logic       busy,
  output logic       echo_sclk,
  output lanes_t     sdi,
  output sample_t    model_sample,
  output logic       model_strobe
);

  localparam int BITS = `ADC_BITS_PER_LANE;

  int busy_left;
  int bit_idx;
  logic sclk_r;
  lanes_t raw_sdi;
  logic [MAX_DELAY-1:0] sclk_pipe;
  lanes_t sdi_pipe [MAX_DELAY];

  // ******************************************************************
  // Conversion with a random busy time and a fresh random result
  // ******************************************************************
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      busy_left    <= 0;
      model_sample <= '0;
      model_strobe <= 1'b0;
    end else begin
      model_strobe <= 1'b0;
      if (cnv) begin
        // Busy stays high for 5 to 20 cycles
        busy         <= 1'b1;
        busy_left    <= int'($urandom_range(20, 5)) - 1;
        model_sample <= sample_t'($urandom);
        model_strobe <= 1'b1;
      end else if (busy) begin
        if (busy_left == 0) begin
          busy <= 1'b0;
        end else begin
          busy_left <= busy_left - 1;
        end
      end
    end
  end

  // ******************************************************************
  // Read frame as the ADC sees it, before the return path delay
  // ******************************************************************

  // The bit index moves on after every falling serial clock edge
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_r  <= 1'b0;
      bit_idx <= 0;
    end else begin
      sclk_r <= spi_sclk;
      if (spi_cs) begin
        bit_idx <= 0;
      end else if (sclk_r && !spi_sclk) begin
        bit_idx <= bit_idx + 1;
      end
    end
  end

  // Lane 0 sends the top slice, each slice goes out MSB first
  always_comb begin
    for (int i = 0; i < `ADC_NUM_LANES; i++) begin
      if (bit_idx < BITS) begin
        raw_sdi[i] = model_sample[`ADC_SAMPLE_WIDTH - 1 - i * BITS - bit_idx];
      end else begin
        raw_sdi[i] = 1'b0;
      end
    end
  end

  // ******************************************************************
  // Return path delay shared by echo clock and data
  // ******************************************************************
  always_ff @(posedge delay_clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_pipe <= '0;
      for (int k = 0; k < MAX_DELAY; k++) begin
        sdi_pipe[k] <= '0;
      end
    end else begin
      sclk_pipe   <= {sclk_pipe[MAX_DELAY-2:0], sclk_r};
      sdi_pipe[0] <= raw_sdi;
      for (int k = 1; k < MAX_DELAY; k++) begin
        sdi_pipe[k] <= sdi_pipe[k-1];
      end
    end
  end

  // A delay of zero leaves only the model's own register
  assign echo_sclk = (echo_delay == 6'd0) ? sclk_r : sclk_pipe[echo_delay - 6'd1];
  assign sdi       = (echo_delay == 6'd0) ? raw_sdi : sdi_pipe[echo_delay - 6'd1];

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic delay_clk,
  output logic rst_n
);

  // Free running clock for the whole front end
  initial begin
    delay_clk = 1'b0;
    forever #(PERIOD_NS / 2) delay_clk = ~delay_clk;
  end

  // Reset is released on a rising edge after RESET_CYCLES edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge delay_clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/adc_if_pkg.sv
rtl/conv_sequencer.sv
rtl/echo_capture.sv
rtl/sample_credit_out.sv
rtl/adc_capture_top.sv
sim/tb_clock_gen.sv
sim/adc_echo_model.sv
sim/adc_capture_tb.sv
